// ==== verilog.f ====
verilog/graph_control_pkg.sv
verilog/job_fifo.sv
verilog/round_robin_grant.sv
verilog/vertex_job_dispatch.sv
verilog/read_command_arbiter.sv
verilog/read_response_router.sv
verilog/progress_counter_sum.sv
verilog/graph_control_top.sv
testbench/graph_control_chk.sv
testbench/graph_control_monitor.sv
testbench/graph_control_tb.sv

// ==== testbench/graph_control_tb.sv ====
`timescale 1ns/1ps

module graph_control_tb;

	localparam int num_cu = 4;
	localparam int fifo_depth = 16;
	localparam int num_rows = 4;
	localparam int row_margin = 150;

	////////////////////
	// stimulus table
	////////////////////

	// jobs, request mask, commands per unit, alfull cycles, responses, then expected outputs
	int row_jobs[num_rows] = '{3, 5, 4, 2};
	logic [num_cu-1:0] row_requests[num_rows] = '{4'b1111, 4'b0101, 4'b0010, 4'b1000};
	int row_commands[num_rows] = '{1, 3, 2, 17};
	int row_alfull[num_rows] = '{0, 0, 12, 24};
	int row_responses[num_rows] = '{4, 6, 3, 2};
	int row_expected_commands[num_rows] = '{4, 12, 8, 64};
	int row_expected_jobs[num_rows] = '{3, 5, 4, 2};

	logic clock, rstn, enabled;
	logic vertex_job_valid;
	logic [graph_control_pkg::VERTEX_ID_WIDTH-1:0] vertex_job_id;
	logic vertex_job_request;
	logic [num_cu-1:0] cu_job_request, cu_job_valid;
	logic [num_cu-1:0][graph_control_pkg::VERTEX_ID_WIDTH-1:0] cu_job_id;
	logic [num_cu-1:0] cu_command_valid, cu_command_full;
	logic [num_cu-1:0][graph_control_pkg::ADDRESS_WIDTH-1:0] cu_command_address;
	logic read_buffer_alfull, read_command_valid;
	logic [graph_control_pkg::ADDRESS_WIDTH-1:0] read_command_address;
	logic [$clog2(num_cu + 1)-1:0] read_command_cu_id, read_response_cu_id;
	logic read_response_valid;
	logic [graph_control_pkg::DATA_WIDTH-1:0] read_response_data;
	logic [num_cu-1:0] cu_response_valid;
	logic [num_cu-1:0][graph_control_pkg::DATA_WIDTH-1:0] cu_response_data;
	logic [num_cu-1:0][graph_control_pkg::COUNTER_WIDTH-1:0] cu_vertex_count, cu_edge_count;
	logic [graph_control_pkg::COUNTER_WIDTH-1:0] vertex_total, edge_total;
	logic test_end, idle;
	int test_index, expected_commands, expected_jobs;
	int error_count, tests_passed, tests_failed, assertion_failures;
	int seed;
	int cycle_count = 0;
	int cycle_limit = 1000000;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	graph_control_top #(
		.num_cu(num_cu),
		.fifo_depth(fifo_depth)
	) graph_control_top_inst (.*);

	graph_control_monitor #(
		.num_cu(num_cu),
		.fifo_depth(fifo_depth)
	) monitor_inst (.*);

	// budget per row grows with its command count
	function automatic int compute_cycle_limit();
		int total;
		total = 10;
		for (int r = 0; r < num_rows; r++) begin
			total += row_expected_commands[r] * graph_control_pkg::THROTTLE_PERIOD + row_margin;
		end
		return total;
	endfunction

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic apply_row(int r);
		int length;
		int sent;
		length = row_commands[r];
		if (row_alfull[r] > length) length = row_alfull[r];
		if (row_responses[r] > length) length = row_responses[r];
		if (row_jobs[r] > length) length = row_jobs[r];
		length += 4;
		sent = 0;
		for (int c = 0; c < length; c++) begin
			@(negedge clock);
			// short pause of all updates
			enabled = !(c == 5 || c == 6);
			read_buffer_alfull = (c < row_alfull[r]);
			cu_job_request = row_requests[r];
			vertex_job_valid = 1'b0;
			if (sent < row_jobs[r] && vertex_job_request) begin
				vertex_job_valid = 1'b1;
				vertex_job_id = 16'(r * 16 + sent);
				sent++;
			end
			cu_command_valid = (c < row_commands[r]) ? '1 : '0;
			read_response_valid = (c < row_responses[r]);
			read_response_cu_id = 3'({$random(seed)} % 6);
			read_response_data = $random(seed);
			for (int i = 0; i < num_cu; i++) begin
				cu_command_address[i] = $random(seed);
				cu_vertex_count[i] = $random(seed);
				cu_edge_count[i] = $random(seed);
			end
		end
		@(negedge clock);
		enabled = 1'b1;
		read_buffer_alfull = 1'b0;
		vertex_job_valid = 1'b0;
		cu_command_valid = '0;
		read_response_valid = 1'b0;
	endtask

	initial begin
		seed = 32'hbaf4c2c7;
		cycle_limit = compute_cycle_limit();
		rstn = 1'b0;
		enabled = 1'b1;
		vertex_job_valid = 1'b0;
		vertex_job_id = '0;
		cu_job_request = '0;
		cu_command_valid = '0;
		cu_command_address = '0;
		read_buffer_alfull = 1'b0;
		read_response_valid = 1'b0;
		read_response_cu_id = '0;
		read_response_data = '0;
		cu_vertex_count = '0;
		cu_edge_count = '0;
		test_end = 1'b0;
		test_index = 0;
		expected_commands = 0;
		expected_jobs = 0;
		repeat (4) @(negedge clock);
		rstn = 1'b1;

		for (int r = 0; r < num_rows; r++) begin
			apply_row(r);
			// drain until the model has nothing pending
			@(negedge clock);
			while (!idle) @(negedge clock);
			test_index = r;
			expected_commands = row_expected_commands[r];
			expected_jobs = row_expected_jobs[r];
			test_end = 1'b1;
			@(negedge clock);
			test_end = 1'b0;
		end
		repeat (2) @(negedge clock);

		assertion_failures = graph_control_top_inst.chk_inst.failure_count;
		$display("tests: %0d passed, %0d failed, %0d value errors, %0d assertion failures",
			tests_passed, tests_failed, error_count, assertion_failures);
		if (tests_failed == 0 && error_count == 0 && assertion_failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== testbench/graph_control_monitor.sv ====
`timescale 1ns/1ps

module graph_control_monitor #(
	parameter int num_cu = 4,
	parameter int fifo_depth = 16
) (
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	input  logic vertex_job_valid,
	input  logic [graph_control_pkg::VERTEX_ID_WIDTH-1:0] vertex_job_id,
	input  logic vertex_job_request,
	input  logic [num_cu-1:0] cu_job_request,
	input  logic [num_cu-1:0] cu_job_valid,
	input  logic [num_cu-1:0][graph_control_pkg::VERTEX_ID_WIDTH-1:0] cu_job_id,
	input  logic [num_cu-1:0] cu_command_valid,
	input  logic [num_cu-1:0][graph_control_pkg::ADDRESS_WIDTH-1:0] cu_command_address,
	input  logic [num_cu-1:0] cu_command_full,
	input  logic read_buffer_alfull,
	input  logic read_command_valid,
	input  logic [graph_control_pkg::ADDRESS_WIDTH-1:0] read_command_address,
	input  logic [$clog2(num_cu + 1)-1:0] read_command_cu_id,
	input  logic read_response_valid,
	input  logic [$clog2(num_cu + 1)-1:0] read_response_cu_id,
	input  logic [graph_control_pkg::DATA_WIDTH-1:0] read_response_data,
	input  logic [num_cu-1:0] cu_response_valid,
	input  logic [num_cu-1:0][graph_control_pkg::DATA_WIDTH-1:0] cu_response_data,
	input  logic [num_cu-1:0][graph_control_pkg::COUNTER_WIDTH-1:0] cu_vertex_count,
	input  logic [num_cu-1:0][graph_control_pkg::COUNTER_WIDTH-1:0] cu_edge_count,
	input  logic [graph_control_pkg::COUNTER_WIDTH-1:0] vertex_total,
	input  logic [graph_control_pkg::COUNTER_WIDTH-1:0] edge_total,
	input  logic test_end,
	input  int test_index,
	input  int expected_commands,
	input  int expected_jobs,
	output logic idle,
	output int error_count,
	output int tests_passed,
	output int tests_failed
);

	logic [graph_control_pkg::VERTEX_ID_WIDTH-1:0] job_q[$];
	logic [graph_control_pkg::ADDRESS_WIDTH-1:0] cmd_mem[num_cu][fifo_depth];
	int cmd_head[num_cu];
	int cmd_count[num_cu];
	bit cmd_full_before[num_cu];
	int job_last, cmd_last, throttle, winner;
	logic [num_cu-1:0] req;
	bit job_full_before;
	logic [num_cu-1:0] exp_job_valid;
	logic [num_cu-1:0][graph_control_pkg::VERTEX_ID_WIDTH-1:0] exp_job_id;
	logic exp_cmd_valid;
	logic [graph_control_pkg::ADDRESS_WIDTH-1:0] exp_cmd_address;
	int exp_cmd_id;
	logic s1_valid;
	int s1_tag;
	logic [graph_control_pkg::DATA_WIDTH-1:0] s1_data;
	logic [num_cu-1:0] exp_resp_valid;
	logic [num_cu-1:0][graph_control_pkg::DATA_WIDTH-1:0] exp_resp_data;
	logic [graph_control_pkg::COUNTER_WIDTH-1:0] exp_vertex_total, exp_edge_total;
	int commands_seen, jobs_seen, test_errors;

	initial begin
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		commands_seen = 0;
		jobs_seen = 0;
		test_errors = 0;
	end

	// rotating priority, search starts after the last winner
	function automatic int pick_next(int last, logic [num_cu-1:0] requests);
		int c;
		for (int off = 1; off <= num_cu; off++) begin
			c = (last + off) % num_cu;
			if (requests[c]) begin
				return c;
			end
		end
		return -1;
	endfunction

	task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	////////////////////
	// reference model
	////////////////////

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_q.delete();
			for (int i = 0; i < num_cu; i++) begin
				cmd_head[i] = 0;
				cmd_count[i] = 0;
			end
			job_last = num_cu - 1;
			cmd_last = num_cu - 1;
			throttle = 0;
			exp_job_valid = '0;
			exp_cmd_valid = 1'b0;
			s1_valid = 1'b0;
			exp_resp_valid = '0;
			exp_vertex_total = '0;
			exp_edge_total = '0;
			idle = 1'b1;
		end else begin
			// jobs
			job_full_before = (job_q.size() == fifo_depth);
			req = (job_q.size() > 0) ? cu_job_request : '0;
			winner = pick_next(job_last, req);
			exp_job_valid = '0;
			if (enabled && winner >= 0) begin
				exp_job_valid[winner] = 1'b1;
				exp_job_id[winner] = job_q.pop_front();
				job_last = winner;
			end
			if (vertex_job_valid && !job_full_before) begin
				job_q.push_back(vertex_job_id);
			end

			// commands
			req = '0;
			for (int i = 0; i < num_cu; i++) begin
				cmd_full_before[i] = (cmd_count[i] == fifo_depth);
				if (throttle == 0 && !read_buffer_alfull) begin
					req[i] = (cmd_count[i] > 0);
				end
			end
			winner = pick_next(cmd_last, req);
			exp_cmd_valid = 1'b0;
			if (enabled && winner >= 0) begin
				exp_cmd_valid = 1'b1;
				exp_cmd_address = cmd_mem[winner][cmd_head[winner]];
				exp_cmd_id = winner;
				cmd_head[winner] = (cmd_head[winner] + 1) % fifo_depth;
				cmd_count[winner]--;
				cmd_last = winner;
			end
			for (int i = 0; i < num_cu; i++) begin
				if (cu_command_valid[i] && !cmd_full_before[i]) begin
					cmd_mem[i][(cmd_head[i] + cmd_count[i]) % fifo_depth] = cu_command_address[i];
					cmd_count[i]++;
				end
			end
			throttle = (throttle + 1) % graph_control_pkg::THROTTLE_PERIOD;

			// responses, two stages
			exp_resp_valid = '0;
			if (s1_valid && s1_tag < num_cu) begin
				exp_resp_valid[s1_tag] = 1'b1;
				exp_resp_data[s1_tag] = s1_data;
			end
			s1_valid = enabled && read_response_valid;
			if (s1_valid) begin
				s1_tag = read_response_cu_id;
				s1_data = read_response_data;
			end

			if (enabled) begin
				exp_vertex_total = '0;
				exp_edge_total = '0;
				for (int i = 0; i < num_cu; i++) begin
					exp_vertex_total += cu_vertex_count[i];
					exp_edge_total += cu_edge_count[i];
				end
			end

			idle = (job_q.size() == 0) && !exp_cmd_valid && !s1_valid
				&& exp_job_valid == '0 && exp_resp_valid == '0;
			for (int i = 0; i < num_cu; i++) begin
				if (cmd_count[i] != 0) begin
					idle = 1'b0;
				end
			end

			if (test_end) begin
				check_value("command count", expected_commands, commands_seen);
				check_value("job count", expected_jobs, jobs_seen);
				if (test_errors == 0) begin
					tests_passed++;
				end else begin
					tests_failed++;
				end
				$display("test %0d: %0d commands, %0d jobs, %0d errors, %s", test_index,
					commands_seen, jobs_seen, test_errors, (test_errors == 0) ? "ok" : "FAILED");
				commands_seen = 0;
				jobs_seen = 0;
				test_errors = 0;
			end
		end
	end

	////////////////////
	// compare, outputs settled
	////////////////////

	always @(negedge clock) begin
		if (rstn) begin
			check_value("vertex_job_request", job_q.size() < fifo_depth - 2, vertex_job_request);
			check_value("cu_job_valid", exp_job_valid, cu_job_valid);
			check_value("read_command_valid", exp_cmd_valid, read_command_valid);
			check_value("cu_response_valid", exp_resp_valid, cu_response_valid);
			check_value("vertex_total", exp_vertex_total, vertex_total);
			check_value("edge_total", exp_edge_total, edge_total);
			for (int i = 0; i < num_cu; i++) begin
				check_value($sformatf("cu_command_full[%0d]", i), cmd_count[i] == fifo_depth,
					cu_command_full[i]);
				if (exp_job_valid[i]) begin
					check_value($sformatf("cu_job_id[%0d]", i), exp_job_id[i], cu_job_id[i]);
				end
				// jobs the DUT really handed out
				if (cu_job_valid[i]) begin
					jobs_seen++;
				end
				if (exp_resp_valid[i]) begin
					check_value($sformatf("cu_response_data[%0d]", i), exp_resp_data[i],
						cu_response_data[i]);
				end
			end
			if (read_command_valid) begin
				commands_seen++;
			end
			if (exp_cmd_valid) begin
				check_value("read_command_address", exp_cmd_address, read_command_address);
				check_value("read_command_cu_id", exp_cmd_id, read_command_cu_id);
			end
		end
	end

endmodule

// ==== testbench/graph_control_chk.sv ====
`timescale 1ns/1ps

module graph_control_chk #(
	parameter int num_cu = 4
) (
	input logic              clock,
	input logic              rstn,
	input logic              read_command_valid,
	input logic              read_buffer_alfull,
	input logic [num_cu-1:0] cu_job_valid,
	input logic [num_cu-1:0] cu_response_valid,
	input logic [num_cu-1:0] cu_command_full
);

	int failure_count = 0;

	// pulses spaced by the throttle period
	assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid |=> !read_command_valid [*graph_control_pkg::THROTTLE_PERIOD-1])
	else begin
		$error("read command pulses closer than the throttle period");
		failure_count++;
	end

	// back-pressure held two cycles stops the output
	assert property (@(posedge clock) disable iff (!rstn)
		read_buffer_alfull ##1 read_buffer_alfull |=> !read_command_valid)
	else begin
		$error("read command issued under back-pressure");
		failure_count++;
	end

	// outputs still clear on the first edge after reset releases
	assert property (@(posedge clock)
		$rose(rstn) |-> (cu_job_valid == '0 && !read_command_valid
			&& cu_response_valid == '0 && cu_command_full == '0))
	else begin
		$error("outputs not cleared by reset");
		failure_count++;
	end

endmodule

bind graph_control_top graph_control_chk #(
	.num_cu(num_cu)
) chk_inst (
	.clock             (clock),
	.rstn              (rstn),
	.read_command_valid(read_command_valid),
	.read_buffer_alfull(read_buffer_alfull),
	.cu_job_valid      (cu_job_valid),
	.cu_response_valid (cu_response_valid),
	.cu_command_full   (cu_command_full)
);

// ==== verilog/graph_control_top.sv ====
`timescale 1ns/1ps

module graph_control_top #(
	parameter int num_cu = 4,
	parameter int fifo_depth = 16
) (
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	// vertex jobs
	input  logic vertex_job_valid,
	input  logic [graph_control_pkg::VERTEX_ID_WIDTH-1:0] vertex_job_id,
	output logic vertex_job_request,
	input  logic [num_cu-1:0] cu_job_request,
	output logic [num_cu-1:0] cu_job_valid,
	output logic [num_cu-1:0][graph_control_pkg::VERTEX_ID_WIDTH-1:0] cu_job_id,
	// read commands
	input  logic [num_cu-1:0] cu_command_valid,
	input  logic [num_cu-1:0][graph_control_pkg::ADDRESS_WIDTH-1:0] cu_command_address,
	output logic [num_cu-1:0] cu_command_full,
	input  logic read_buffer_alfull,
	output logic read_command_valid,
	output logic [graph_control_pkg::ADDRESS_WIDTH-1:0] read_command_address,
	output logic [$clog2(num_cu + 1)-1:0] read_command_cu_id,
	// read responses
	input  logic read_response_valid,
	input  logic [$clog2(num_cu + 1)-1:0] read_response_cu_id,
	input  logic [graph_control_pkg::DATA_WIDTH-1:0] read_response_data,
	output logic [num_cu-1:0] cu_response_valid,
	output logic [num_cu-1:0][graph_control_pkg::DATA_WIDTH-1:0] cu_response_data,
	// progress counters
	input  logic [num_cu-1:0][graph_control_pkg::COUNTER_WIDTH-1:0] cu_vertex_count,
	input  logic [num_cu-1:0][graph_control_pkg::COUNTER_WIDTH-1:0] cu_edge_count,
	output logic [graph_control_pkg::COUNTER_WIDTH-1:0] vertex_total,
	output logic [graph_control_pkg::COUNTER_WIDTH-1:0] edge_total
);

	vertex_job_dispatch #(
		.num_cu    (num_cu),
		.fifo_depth(fifo_depth)
	) vertex_job_dispatch_inst (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.vertex_job_valid  (vertex_job_valid),
		.vertex_job_id     (vertex_job_id),
		.vertex_job_request(vertex_job_request),
		.cu_job_request    (cu_job_request),
		.cu_job_valid      (cu_job_valid),
		.cu_job_id         (cu_job_id)
	);

	read_command_arbiter #(
		.num_cu    (num_cu),
		.fifo_depth(fifo_depth)
	) read_command_arbiter_inst (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (enabled),
		.cu_command_valid    (cu_command_valid),
		.cu_command_address  (cu_command_address),
		.cu_command_full     (cu_command_full),
		.read_buffer_alfull  (read_buffer_alfull),
		.read_command_valid  (read_command_valid),
		.read_command_address(read_command_address),
		.read_command_cu_id  (read_command_cu_id)
	);

	read_response_router #(
		.num_cu(num_cu)
	) read_response_router_inst (
		.clock              (clock),
		.rstn               (rstn),
		.enabled            (enabled),
		.read_response_valid(read_response_valid),
		.read_response_cu_id(read_response_cu_id),
		.read_response_data (read_response_data),
		.cu_response_valid  (cu_response_valid),
		.cu_response_data   (cu_response_data)
	);

	progress_counter_sum #(
		.num_cu(num_cu)
	) progress_counter_sum_inst (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.cu_vertex_count(cu_vertex_count),
		.cu_edge_count  (cu_edge_count),
		.vertex_total   (vertex_total),
		.edge_total     (edge_total)
	);

endmodule

// ==== verilog/progress_counter_sum.sv ====
`timescale 1ns/1ps

module progress_counter_sum #(
	parameter int num_cu = 4
) (
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	input  logic [num_cu-1:0][graph_control_pkg::COUNTER_WIDTH-1:0] cu_vertex_count,
	input  logic [num_cu-1:0][graph_control_pkg::COUNTER_WIDTH-1:0] cu_edge_count,
	output logic [graph_control_pkg::COUNTER_WIDTH-1:0] vertex_total,
	output logic [graph_control_pkg::COUNTER_WIDTH-1:0] edge_total
);

	logic [graph_control_pkg::COUNTER_WIDTH-1:0] vertex_sum;
	logic [graph_control_pkg::COUNTER_WIDTH-1:0] edge_sum;

	// wraps at counter width like the unit counters
	always_comb begin
		vertex_sum = '0;
		edge_sum = '0;
		for (int i = 0; i < num_cu; i++) begin
			vertex_sum = vertex_sum + cu_vertex_count[i];
			edge_sum = edge_sum + cu_edge_count[i];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_total <= '0;
			edge_total <= '0;
		end else if (enabled) begin
			vertex_total <= vertex_sum;
			edge_total <= edge_sum;
		end
	end

endmodule

// ==== verilog/read_response_router.sv ====
`timescale 1ns/1ps

module read_response_router #(
	parameter int num_cu = 4
) (
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	input  logic read_response_valid,
	input  logic [$clog2(num_cu + 1)-1:0] read_response_cu_id,
	input  logic [graph_control_pkg::DATA_WIDTH-1:0] read_response_data,
	output logic [num_cu-1:0] cu_response_valid,
	output logic [num_cu-1:0][graph_control_pkg::DATA_WIDTH-1:0] cu_response_data
);

	localparam int cu_id_width = $clog2(num_cu + 1);

	logic response_valid_q;
	logic [cu_id_width-1:0] response_cu_id_q;
	logic [graph_control_pkg::DATA_WIDTH-1:0] response_data_q;

	// first stage, input latch
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_valid_q <= 1'b0;
		end else begin
			response_valid_q <= enabled && read_response_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && read_response_valid) begin
			response_cu_id_q <= read_response_cu_id;
			response_data_q <= read_response_data;
		end
	end

	// second stage, tag decode
	// tags of num_cu and up match no unit and fall away here
	for (genvar i = 0; i < num_cu; i++) begin : gen_route
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				cu_response_valid[i] <= 1'b0;
			end else begin
				cu_response_valid[i] <= response_valid_q
					&& (response_cu_id_q == cu_id_width'(i));
			end
		end

		always_ff @(posedge clock) begin
			if (response_valid_q && (response_cu_id_q == cu_id_width'(i))) begin
				cu_response_data[i] <= response_data_q;
			end
		end
	end

endmodule

// ==== verilog/read_command_arbiter.sv ====
`timescale 1ns/1ps

module read_command_arbiter #(
	parameter int num_cu = 4,
	parameter int fifo_depth = 16
) (
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	input  logic [num_cu-1:0] cu_command_valid,
	input  logic [num_cu-1:0][graph_control_pkg::ADDRESS_WIDTH-1:0] cu_command_address,
	output logic [num_cu-1:0] cu_command_full,
	input  logic read_buffer_alfull,
	output logic read_command_valid,
	output logic [graph_control_pkg::ADDRESS_WIDTH-1:0] read_command_address,
	output logic [$clog2(num_cu + 1)-1:0] read_command_cu_id
);

	// tag has room for one code past the last unit
	localparam int cu_id_width = $clog2(num_cu + 1);
	localparam int throttle_width =
		(graph_control_pkg::THROTTLE_PERIOD > 1) ? $clog2(graph_control_pkg::THROTTLE_PERIOD) : 1;

	logic [throttle_width-1:0] throttle_count;
	logic [num_cu-1:0][graph_control_pkg::ADDRESS_WIDTH-1:0] head_address;
	logic [num_cu-1:0] buffer_empty;
	logic [num_cu-1:0] command_requests;
	logic [num_cu-1:0] command_grant;
	logic [graph_control_pkg::ADDRESS_WIDTH-1:0] selected_address;
	logic [cu_id_width-1:0] selected_cu_id;

	////////////////////
	// throttle
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			throttle_count <= '0;
		end else if (throttle_count == throttle_width'(graph_control_pkg::THROTTLE_PERIOD - 1)) begin
			throttle_count <= '0;
		end else begin
			throttle_count <= throttle_count + 1'b1;
		end
	end

	////////////////////
	// per-unit buffers
	////////////////////

	for (genvar i = 0; i < num_cu; i++) begin : gen_command_buffer
		job_fifo #(
			.width(graph_control_pkg::ADDRESS_WIDTH),
			.depth(fifo_depth)
		) command_fifo (
			.clock      (clock),
			.rstn       (rstn),
			.push       (cu_command_valid[i]),
			.data_in    (cu_command_address[i]),
			.pop        (command_grant[i]),
			.data_out   (head_address[i]),
			.full       (cu_command_full[i]),
			.almost_full(),
			.empty      (buffer_empty[i])
		);

		assign command_requests[i] = !buffer_empty[i] && (throttle_count == '0)
			&& !read_buffer_alfull;
	end

	round_robin_grant #(
		.num_cu(num_cu)
	) command_grant_arbiter (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (enabled),
		.requests(command_requests),
		.grant   (command_grant)
	);

	// one-hot grant to winner head and tag
	always_comb begin
		selected_address = '0;
		selected_cu_id = '0;
		for (int i = 0; i < num_cu; i++) begin
			if (command_grant[i]) begin
				selected_address = head_address[i];
				selected_cu_id = cu_id_width'(i);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_valid <= 1'b0;
		end else begin
			read_command_valid <= |command_grant;
		end
	end

	always_ff @(posedge clock) begin
		if (|command_grant) begin
			read_command_address <= selected_address;
			read_command_cu_id <= selected_cu_id;
		end
	end

endmodule

// ==== verilog/vertex_job_dispatch.sv ====
`timescale 1ns/1ps

module vertex_job_dispatch #(
	parameter int num_cu = 4,
	parameter int fifo_depth = 16
) (
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	input  logic vertex_job_valid,
	input  logic [graph_control_pkg::VERTEX_ID_WIDTH-1:0] vertex_job_id,
	output logic vertex_job_request,
	input  logic [num_cu-1:0] cu_job_request,
	output logic [num_cu-1:0] cu_job_valid,
	output logic [num_cu-1:0][graph_control_pkg::VERTEX_ID_WIDTH-1:0] cu_job_id
);

	logic [graph_control_pkg::VERTEX_ID_WIDTH-1:0] head_job;
	logic buffer_almost_full;
	logic buffer_empty;
	logic [num_cu-1:0] masked_requests;
	logic [num_cu-1:0] job_grant;

	// keep two slots spare for jobs already on their way
	assign vertex_job_request = !buffer_almost_full;

	job_fifo #(
		.width(graph_control_pkg::VERTEX_ID_WIDTH),
		.depth(fifo_depth)
	) vertex_job_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (vertex_job_valid),
		.data_in    (vertex_job_id),
		.pop        (|job_grant),
		.data_out   (head_job),
		.full       (),
		.almost_full(buffer_almost_full),
		.empty      (buffer_empty)
	);

	// only ask for a winner when a job is waiting
	assign masked_requests = cu_job_request & {num_cu{!buffer_empty}};

	round_robin_grant #(
		.num_cu(num_cu)
	) job_grant_arbiter (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (enabled),
		.requests(masked_requests),
		.grant   (job_grant)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_job_valid <= '0;
		end else begin
			cu_job_valid <= job_grant;
		end
	end

	// job id only loaded for the granted unit
	always_ff @(posedge clock) begin
		for (int i = 0; i < num_cu; i++) begin
			if (job_grant[i]) begin
				cu_job_id[i] <= head_job;
			end
		end
	end

endmodule

// ==== verilog/round_robin_grant.sv ====
`timescale 1ns/1ps

module round_robin_grant #(
	parameter int num_cu = 4
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  logic [num_cu-1:0] requests,
	output logic [num_cu-1:0] grant
);

	localparam int index_width = (num_cu > 1) ? $clog2(num_cu) : 1;

	logic [index_width-1:0] last_winner;
	logic [index_width-1:0] next_winner;
	logic found;
	int unsigned candidate;

	// search upward from the unit after the last winner, wrapping around
	always_comb begin
		grant = '0;
		next_winner = last_winner;
		found = 1'b0;
		candidate = 0;
		for (int unsigned offset = 1; offset <= num_cu; offset++) begin
			candidate = (last_winner + offset) % num_cu;
			if (!found && requests[candidate]) begin
				found = 1'b1;
				grant[candidate] = enabled;
				next_winner = index_width'(candidate);
			end
		end
	end

	// starting at the top index makes unit 0 first after reset
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_winner <= index_width'(num_cu - 1);
		end else if (enabled && found) begin
			last_winner <= next_winner;
		end
	end

endmodule

// ==== verilog/job_fifo.sv ====
`timescale 1ns/1ps

module job_fifo #(
	parameter int width = 32,
	parameter int depth = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [width-1:0] data_in,
	input  logic             pop,
	output logic [width-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_width = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [count_width-1:0] count;
	logic do_push;
	logic do_pop;

	// push into a full buffer or pop from an empty one is ignored
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == count_width'(depth));
	// two or fewer free slots left
	assign almost_full = (count >= count_width'(depth - 2));
	assign empty = (count == '0);
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== verilog/graph_control_pkg.sv ====
package graph_control_pkg;

	////////////////////
	// datapath widths
	////////////////////

	localparam int VERTEX_ID_WIDTH = 16;
	localparam int ADDRESS_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int COUNTER_WIDTH = 32;

	////////////////////
	// read command pacing
	////////////////////

	// cycles between two possible read command grants
	localparam int THROTTLE_PERIOD = 4;

endpackage
